/* verilog/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Field widths
`define REG_W   5
`define IMM_W   16
`define JIMM_W  26
`define OP_W    22

`define RA_REG  5'd31   // JAL link register

// One-hot operation bit positions
`define OP_ADDU   0
`define OP_SUBU   1
`define OP_AND    2
`define OP_OR     3
`define OP_SLT    4
`define OP_SLL    5
`define OP_SRL    6
`define OP_JR     7
`define OP_ADDIU  8
`define OP_ANDI   9
`define OP_ORI    10
`define OP_LUI    11
`define OP_LW     12
`define OP_SW     13
`define OP_BEQ    14
`define OP_BNE    15
`define OP_J      16
`define OP_JAL    17
`define OP_TLBP   18
`define OP_TLBR   19
`define OP_TLBWI  20
`define OP_RSVD   21

// Primary opcodes
`define OPC_SPECIAL 6'h00
`define OPC_J       6'h02
`define OPC_JAL     6'h03
`define OPC_BEQ     6'h04
`define OPC_BNE     6'h05
`define OPC_ADDIU   6'h09
`define OPC_ANDI    6'h0c
`define OPC_ORI     6'h0d
`define OPC_LUI     6'h0f
`define OPC_COP0    6'h10
`define OPC_LW      6'h23
`define OPC_SW      6'h2b

// SPECIAL funct values
`define FN_SLL   6'h00
`define FN_SRL   6'h02
`define FN_JR    6'h08
`define FN_ADDU  6'h21
`define FN_SUBU  6'h23
`define FN_AND   6'h24
`define FN_OR    6'h25
`define FN_SLT   6'h2a

// COP0 with CO bit set in rs, function in low six bits
`define COP0_CO    5'h10
`define C0F_TLBR   6'h01
`define C0F_TLBWI  6'h02
`define C0F_TLBP   6'h08

`endif

/* verilog/decode_pkg.sv */
`include "decode_macros.svh"

package decode_pkg;

    // Register format, also used for the jump target
    typedef struct packed {
        logic [5:0]        opcode;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
        logic [`REG_W-1:0] rd;
        logic [`REG_W-1:0] sa;
        logic [5:0]        funct;
    } inst_r_t;

    // Immediate format
    typedef struct packed {
        logic [5:0]        opcode;
        logic [`REG_W-1:0] rs;
        logic [`REG_W-1:0] rt;
        logic [`IMM_W-1:0] imm;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_word_u;

endpackage

/* verilog/id1_if.sv */
`timescale 1ns/1ns
`include "decode_macros.svh"

interface id1_if;

    // Classifier results
    logic [`OP_W-1:0]   op_codes;
    logic               is_branch;
    logic               is_j_imme;
    logic               is_jr;
    logic               is_ls;
    logic               is_tlbp;
    logic               is_tlbr;
    logic               is_tlbwi;
    logic               w_reg_ena;

    // Operand fields
    logic [`REG_W-1:0]  rs;
    logic [`REG_W-1:0]  rt;
    logic [`REG_W-1:0]  rd;
    logic [`REG_W-1:0]  sa;
    logic [`IMM_W-1:0]  imme;
    logic [`JIMM_W-1:0] j_imme;
    logic [`REG_W-1:0]  w_reg_dst;

    modport cls_mp (
        output op_codes, is_branch, is_j_imme, is_jr, is_ls,
               is_tlbp, is_tlbr, is_tlbwi, w_reg_ena
    );

    modport opr_mp (
        output rs, rt, rd, sa, imme, j_imme, w_reg_dst
    );

    modport stage_mp (
        input op_codes, is_branch, is_j_imme, is_jr, is_ls,
              is_tlbp, is_tlbr, is_tlbwi, w_reg_ena,
              rs, rt, rd, sa, imme, j_imme, w_reg_dst
    );

endinterface

/* verilog/op_classifier.sv */
`timescale 1ns/1ns
`include "decode_macros.svh"

module op_classifier
    import decode_pkg::*;
(
    input  inst_word_u  inst_i,
    id1_if.cls_mp       cls
);

    logic [`OP_W-1:0] op;

    always_comb begin
        op = '0;
        case (inst_i.r.opcode)
            `OPC_SPECIAL: begin
                case (inst_i.r.funct)
                    `FN_ADDU: op[`OP_ADDU] = 1'b1;
                    `FN_SUBU: op[`OP_SUBU] = 1'b1;
                    `FN_AND:  op[`OP_AND]  = 1'b1;
                    `FN_OR:   op[`OP_OR]   = 1'b1;
                    `FN_SLT:  op[`OP_SLT]  = 1'b1;
                    `FN_SLL:  op[`OP_SLL]  = 1'b1;
                    `FN_SRL:  op[`OP_SRL]  = 1'b1;
                    `FN_JR:   op[`OP_JR]   = 1'b1;
                    default:  op[`OP_RSVD] = 1'b1;
                endcase
            end
            `OPC_ADDIU: op[`OP_ADDIU] = 1'b1;
            `OPC_ANDI:  op[`OP_ANDI]  = 1'b1;
            `OPC_ORI:   op[`OP_ORI]   = 1'b1;
            `OPC_LUI:   op[`OP_LUI]   = 1'b1;
            `OPC_LW:    op[`OP_LW]    = 1'b1;
            `OPC_SW:    op[`OP_SW]    = 1'b1;
            `OPC_BEQ:   op[`OP_BEQ]   = 1'b1;
            `OPC_BNE:   op[`OP_BNE]   = 1'b1;
            `OPC_J:     op[`OP_J]     = 1'b1;
            `OPC_JAL:   op[`OP_JAL]   = 1'b1;
            `OPC_COP0: begin
                // TLB ops need the CO bit pattern in rs
                if (inst_i.r.rs != `COP0_CO) begin
                    op[`OP_RSVD] = 1'b1;
                end else begin
                    case (inst_i.r.funct)
                        `C0F_TLBP:  op[`OP_TLBP]  = 1'b1;
                        `C0F_TLBR:  op[`OP_TLBR]  = 1'b1;
                        `C0F_TLBWI: op[`OP_TLBWI] = 1'b1;
                        default:    op[`OP_RSVD]  = 1'b1;
                    endcase
                end
            end
            default: op[`OP_RSVD] = 1'b1;
        endcase
    end

    assign cls.op_codes  = op;
    assign cls.is_branch = op[`OP_BEQ] | op[`OP_BNE];
    assign cls.is_j_imme = op[`OP_J] | op[`OP_JAL];
    assign cls.is_jr     = op[`OP_JR];
    assign cls.is_ls     = op[`OP_LW] | op[`OP_SW];
    assign cls.is_tlbp   = op[`OP_TLBP];
    assign cls.is_tlbr   = op[`OP_TLBR];
    assign cls.is_tlbwi  = op[`OP_TLBWI];

    // Everything that produces a GPR result
    assign cls.w_reg_ena = op[`OP_ADDU]  | op[`OP_SUBU] | op[`OP_AND]  | op[`OP_OR]
                         | op[`OP_SLT]   | op[`OP_SLL]  | op[`OP_SRL]
                         | op[`OP_ADDIU] | op[`OP_ANDI] | op[`OP_ORI]  | op[`OP_LUI]
                         | op[`OP_LW]    | op[`OP_JAL];

endmodule

/* verilog/operand_extract.sv */
`timescale 1ns/1ns
`include "decode_macros.svh"

module operand_extract
    import decode_pkg::*;
(
    input  inst_word_u  inst_i,
    id1_if.opr_mp       opr
);

    logic [5:0]        opcode;
    logic [`REG_W-1:0] dst;

    assign opcode = inst_i.i.opcode;

    assign opr.rs     = inst_i.r.rs;
    assign opr.rt     = inst_i.r.rt;
    assign opr.rd     = inst_i.r.rd;
    assign opr.sa     = inst_i.r.sa;
    assign opr.imme   = inst_i.i.imm;
    assign opr.j_imme = inst_i.r[`JIMM_W-1:0];  // Jump target field

    // Destination register, independent of the write enable
    always_comb begin
        case (opcode)
            `OPC_SPECIAL: dst = inst_i.r.rd;
            `OPC_JAL:     dst = `RA_REG;
            default:      dst = inst_i.i.rt;
        endcase
    end

    assign opr.w_reg_dst = dst;

endmodule

/* verilog/issue_id2.sv */
`timescale 1ns/1ns
`include "decode_macros.svh"

module issue_id2 (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               exception_flush_i,
    input  logic               stall_i,
    input  logic               valid_i,
    input  logic [31:0]        pc_i,
    input  logic [31:0]        inst_i,
    input  logic               in_delay_slot_i,
    input  logic               inst_adel_i,
    input  logic               i_refill_tlbl_i,
    input  logic               i_invalid_tlbl_i,
    input  logic               refetch_i,
    id1_if.stage_mp            dec,

    output logic               valid_o,
    output logic [31:0]        pc_o,
    output logic [31:0]        inst_o,
    output logic               in_delay_slot_o,
    output logic               inst_adel_o,
    output logic               i_refill_tlbl_o,
    output logic               i_invalid_tlbl_o,
    output logic               refetch_o,
    output logic [`OP_W-1:0]   op_codes_o,
    output logic               is_branch_o,
    output logic               is_j_imme_o,
    output logic               is_jr_o,
    output logic               is_ls_o,
    output logic               is_tlbp_o,
    output logic               is_tlbr_o,
    output logic               is_tlbwi_o,
    output logic               w_reg_ena_o,
    output logic [`REG_W-1:0]  rs_o,
    output logic [`REG_W-1:0]  rt_o,
    output logic [`REG_W-1:0]  rd_o,
    output logic [`REG_W-1:0]  sa_o,
    output logic [`IMM_W-1:0]  imme_o,
    output logic [`JIMM_W-1:0] j_imme_o,
    output logic [`REG_W-1:0]  w_reg_dst_o
);

    logic clear;
    logic load;

    // Exception flush wins over stall, a plain flush does not
    assign clear = rst_i | exception_flush_i | (flush_i & ~stall_i) | (~valid_i & ~stall_i);
    assign load  = ~flush_i & ~stall_i;

    always_ff @(posedge clk) begin
        if (clear) begin
            valid_o          <= 1'b0;
            pc_o             <= '0;
            inst_o           <= '0;
            in_delay_slot_o  <= 1'b0;
            inst_adel_o      <= 1'b0;
            i_refill_tlbl_o  <= 1'b0;
            i_invalid_tlbl_o <= 1'b0;
            refetch_o        <= 1'b0;
            op_codes_o       <= '0;
            is_branch_o      <= 1'b0;
            is_j_imme_o      <= 1'b0;
            is_jr_o          <= 1'b0;
            is_ls_o          <= 1'b0;
            is_tlbp_o        <= 1'b0;
            is_tlbr_o        <= 1'b0;
            is_tlbwi_o       <= 1'b0;
            w_reg_ena_o      <= 1'b0;
            rs_o             <= '0;
            rt_o             <= '0;
            rd_o             <= '0;
            sa_o             <= '0;
            imme_o           <= '0;
            j_imme_o         <= '0;
            w_reg_dst_o      <= '0;
        end else if (load) begin
            valid_o          <= valid_i;
            pc_o             <= pc_i;
            inst_o           <= inst_i;
            in_delay_slot_o  <= in_delay_slot_i;
            inst_adel_o      <= inst_adel_i;
            i_refill_tlbl_o  <= i_refill_tlbl_i;
            i_invalid_tlbl_o <= i_invalid_tlbl_i;
            refetch_o        <= refetch_i;
            op_codes_o       <= dec.op_codes;
            is_branch_o      <= dec.is_branch;
            is_j_imme_o      <= dec.is_j_imme;
            is_jr_o          <= dec.is_jr;
            is_ls_o          <= dec.is_ls;
            is_tlbp_o        <= dec.is_tlbp;
            is_tlbr_o        <= dec.is_tlbr;
            is_tlbwi_o       <= dec.is_tlbwi;
            w_reg_ena_o      <= dec.w_reg_ena;
            rs_o             <= dec.rs;
            rt_o             <= dec.rt;
            rd_o             <= dec.rd;
            sa_o             <= dec.sa;
            imme_o           <= dec.imme;
            j_imme_o         <= dec.j_imme;
            w_reg_dst_o      <= dec.w_reg_dst;
        end
        // Stall with flush falls through and holds
    end

endmodule

/* verilog/decode_top.sv */
`timescale 1ns/1ns
`include "decode_macros.svh"

module decode_top (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               exception_flush_i,
    input  logic               stall_i,
    input  logic               valid_i,
    input  logic [31:0]        pc_i,
    input  logic [31:0]        inst_i,
    input  logic               in_delay_slot_i,
    input  logic               inst_adel_i,
    input  logic               i_refill_tlbl_i,
    input  logic               i_invalid_tlbl_i,
    input  logic               refetch_i,

    output logic               valid_o,
    output logic [31:0]        pc_o,
    output logic [31:0]        inst_o,
    output logic               in_delay_slot_o,
    output logic               inst_adel_o,
    output logic               i_refill_tlbl_o,
    output logic               i_invalid_tlbl_o,
    output logic               refetch_o,
    output logic [`OP_W-1:0]   op_codes_o,
    output logic               is_branch_o,
    output logic               is_j_imme_o,
    output logic               is_jr_o,
    output logic               is_ls_o,
    output logic               is_tlbp_o,
    output logic               is_tlbr_o,
    output logic               is_tlbwi_o,
    output logic               w_reg_ena_o,
    output logic [`REG_W-1:0]  rs_o,
    output logic [`REG_W-1:0]  rt_o,
    output logic [`REG_W-1:0]  rd_o,
    output logic [`REG_W-1:0]  sa_o,
    output logic [`IMM_W-1:0]  imme_o,
    output logic [`JIMM_W-1:0] j_imme_o,
    output logic [`REG_W-1:0]  w_reg_dst_o
);

    id1_if dec_if ();

    // Both decoders see the same word in parallel
    op_classifier i_op_classifier (
        .inst_i (inst_i),
        .cls    (dec_if.cls_mp)
    );

    operand_extract i_operand_extract (
        .inst_i (inst_i),
        .opr    (dec_if.opr_mp)
    );

    issue_id2 i_issue_id2 (
        .clk               (clk),
        .rst_i             (rst_i),
        .flush_i           (flush_i),
        .exception_flush_i (exception_flush_i),
        .stall_i           (stall_i),
        .valid_i           (valid_i),
        .pc_i              (pc_i),
        .inst_i            (inst_i),
        .in_delay_slot_i   (in_delay_slot_i),
        .inst_adel_i       (inst_adel_i),
        .i_refill_tlbl_i   (i_refill_tlbl_i),
        .i_invalid_tlbl_i  (i_invalid_tlbl_i),
        .refetch_i         (refetch_i),
        .dec               (dec_if.stage_mp),
        .valid_o           (valid_o),
        .pc_o              (pc_o),
        .inst_o            (inst_o),
        .in_delay_slot_o   (in_delay_slot_o),
        .inst_adel_o       (inst_adel_o),
        .i_refill_tlbl_o   (i_refill_tlbl_o),
        .i_invalid_tlbl_o  (i_invalid_tlbl_o),
        .refetch_o         (refetch_o),
        .op_codes_o        (op_codes_o),
        .is_branch_o       (is_branch_o),
        .is_j_imme_o       (is_j_imme_o),
        .is_jr_o           (is_jr_o),
        .is_ls_o           (is_ls_o),
        .is_tlbp_o         (is_tlbp_o),
        .is_tlbr_o         (is_tlbr_o),
        .is_tlbwi_o        (is_tlbwi_o),
        .w_reg_ena_o       (w_reg_ena_o),
        .rs_o              (rs_o),
        .rt_o              (rt_o),
        .rd_o              (rd_o),
        .sa_o              (sa_o),
        .imme_o            (imme_o),
        .j_imme_o          (j_imme_o),
        .w_reg_dst_o       (w_reg_dst_o)
    );

endmodule

/* verification/decode_chk.sv */
`timescale 1ns/1ns
`include "decode_macros.svh"

module decode_chk (
    input logic             clk,
    input logic             rst_i,
    input logic             exception_flush_i,
    input logic             stall_i,
    input logic             valid_o,
    input logic [`OP_W-1:0] op_codes_o,
    input logic [166:0]     record_i      // All registered outputs
);

    int fail_count = 0;

    a_reset: assert property (@(posedge clk) rst_i |=> !valid_o)
        else begin
            $error("valid_o high in the cycle after reset");
            fail_count++;
        end

    a_exc_flush: assert property (@(posedge clk) exception_flush_i |=> !valid_o)
        else begin
            $error("valid_o high after an exception flush");
            fail_count++;
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (rst_i)
        stall_i && !exception_flush_i |=> $stable(record_i))
        else begin
            $error("record changed while stalled");
            fail_count++;
        end

    a_onehot: assert property (@(posedge clk) disable iff (rst_i)
        valid_o ? $onehot(op_codes_o) : (op_codes_o == '0))
        else begin
            $error("op_codes_o not one-hot for a valid record or not zero for a bubble");
            fail_count++;
        end

endmodule

bind issue_id2 decode_chk i_decode_chk (
    .clk               (clk),
    .rst_i             (rst_i),
    .exception_flush_i (exception_flush_i),
    .stall_i           (stall_i),
    .valid_o           (valid_o),
    .op_codes_o        (op_codes_o),
    .record_i          ({valid_o, pc_o, inst_o, in_delay_slot_o, inst_adel_o,
                         i_refill_tlbl_o, i_invalid_tlbl_o, refetch_o, op_codes_o,
                         is_branch_o, is_j_imme_o, is_jr_o, is_ls_o, is_tlbp_o,
                         is_tlbr_o, is_tlbwi_o, w_reg_ena_o, rs_o, rt_o, rd_o, sa_o,
                         imme_o, j_imme_o, w_reg_dst_o})
);

/* verification/decode_tb.sv */
`timescale 1ns/1ns
`include "decode_macros.svh"

module decode_tb;

    // Flag vector order {branch, j_imme, jr, ls, tlbp, tlbr, tlbwi, w_reg_ena}
    localparam logic [7:0] F_BR    = 8'h80;
    localparam logic [7:0] F_J     = 8'h40;
    localparam logic [7:0] F_JR    = 8'h20;
    localparam logic [7:0] F_LS    = 8'h10;
    localparam logic [7:0] F_TLBP  = 8'h08;
    localparam logic [7:0] F_TLBR  = 8'h04;
    localparam logic [7:0] F_TLBWI = 8'h02;
    localparam logic [7:0] F_WR    = 8'h01;
    localparam int STEPS = 32;              // Checked edges over all tests

    logic clk, rst_i, flush_i, exception_flush_i, stall_i, valid_i;
    logic [31:0] pc_i, inst_i, pc_o, inst_o;
    logic in_delay_slot_i, inst_adel_i, i_refill_tlbl_i, i_invalid_tlbl_i, refetch_i;
    logic valid_o, in_delay_slot_o, inst_adel_o, i_refill_tlbl_o, i_invalid_tlbl_o, refetch_o;
    logic [`OP_W-1:0] op_codes_o;
    logic is_branch_o, is_j_imme_o, is_jr_o, is_ls_o, is_tlbp_o, is_tlbr_o, is_tlbwi_o;
    logic w_reg_ena_o;
    logic [`REG_W-1:0] rs_o, rt_o, rd_o, sa_o, w_reg_dst_o;
    logic [`IMM_W-1:0] imme_o;
    logic [`JIMM_W-1:0] j_imme_o;

    // Pending inputs and the record expected at the outputs
    logic [31:0] p_pc, p_inst, e_pc, e_inst;
    logic [4:0] p_fl, p_dst, e_fl, e_dst;
    logic [7:0] p_flags, e_flags;
    logic [`OP_W-1:0] p_op, e_op;
    logic e_valid;
    int errors = 0;
    int chk_errors = 0;

    decode_top i_decode_top (.*);

    always #5 clk = ~clk;

    initial begin
        #((STEPS * 20 + 16) * 10);
        $display("Timeout, the run stopped before the last test finished");
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sa);
        return {`OPC_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] opc, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    task automatic cmp(input string name, input string field, input logic [31:0] exp,
                       input logic [31:0] act);
        assert (exp === act) else begin
            $display("MISMATCH %s %s expected %h actual %h", name, field, exp, act);
            errors++;
        end
    endtask

    task automatic check_record(input string name);
        cmp(name, "valid", e_valid, valid_o);
        cmp(name, "pc", e_pc, pc_o);
        cmp(name, "inst", e_inst, inst_o);
        cmp(name, "fetch flags", e_fl,
            {in_delay_slot_o, inst_adel_o, i_refill_tlbl_o, i_invalid_tlbl_o, refetch_o});
        cmp(name, "op_codes", e_op, op_codes_o);
        cmp(name, "flags", e_flags, {is_branch_o, is_j_imme_o, is_jr_o, is_ls_o,
                                     is_tlbp_o, is_tlbr_o, is_tlbwi_o, w_reg_ena_o});
        cmp(name, "rs", e_inst[25:21], rs_o);   // ISA field positions
        cmp(name, "rt", e_inst[20:16], rt_o);
        cmp(name, "rd", e_inst[15:11], rd_o);
        cmp(name, "sa", e_inst[10:6], sa_o);
        cmp(name, "imme", e_inst[15:0], imme_o);
        cmp(name, "j_imme", e_inst[25:0], j_imme_o);
        cmp(name, "w_reg_dst", e_dst, w_reg_dst_o);
    endtask

    task automatic apply_inst(input logic [31:0] inst, input int bit_pos,
                              input logic [7:0] flags, input logic [4:0] dst);
        @(posedge clk);
        p_inst = inst;
        p_pc = $urandom;
        p_fl = $urandom;
        p_op = '0;
        p_op[bit_pos] = 1'b1;
        p_flags = flags;
        p_dst = dst;
        inst_i <= p_inst;
        pc_i <= p_pc;
        valid_i <= 1'b1;
        {in_delay_slot_i, inst_adel_i, i_refill_tlbl_i, i_invalid_tlbl_i, refetch_i} <= p_fl;
    endtask

    task automatic commit_expect();
        e_valid = 1'b1;
        e_pc = p_pc;
        e_inst = p_inst;
        e_fl = p_fl;
        e_op = p_op;
        e_flags = p_flags;
        e_dst = p_dst;
    endtask

    task automatic clear_expect();
        e_valid = 1'b0;
        e_pc = '0;
        e_inst = '0;
        e_fl = '0;
        e_op = '0;
        e_flags = '0;
        e_dst = '0;
    endtask

    task automatic next_edge();
        @(posedge clk);
        @(negedge clk);    // Outputs settled
    endtask

    task automatic run_one(input string name, input logic [31:0] inst, input int bit_pos,
                           input logic [7:0] flags, input logic [4:0] dst);
        apply_inst(inst, bit_pos, flags, dst);
        commit_expect();
        next_edge();
        check_record(name);
    endtask

    task automatic test_rtype();
        logic [5:0] fn [8];
        logic [4:0] rd;
        fn = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_SLT, `FN_SLL, `FN_SRL, `FN_JR};
        for (int k = 0; k < 8; k++) begin
            rd = $urandom;
            run_one("test_rtype", r_word(fn[k], $urandom, $urandom, rd, $urandom),
                    `OP_ADDU + k, (fn[k] == `FN_JR) ? F_JR : F_WR, rd);
        end
    endtask

    task automatic test_itype();
        logic [5:0] opc [6];
        logic [4:0] rt;
        logic [7:0] flags;
        opc = '{`OPC_ADDIU, `OPC_ANDI, `OPC_ORI, `OPC_LUI, `OPC_LW, `OPC_SW};
        for (int k = 0; k < 6; k++) begin
            rt = $urandom;
            flags = (opc[k] == `OPC_LW) ? (F_LS | F_WR) : (opc[k] == `OPC_SW) ? F_LS : F_WR;
            run_one("test_itype", i_word(opc[k], $urandom, rt, $urandom),
                    `OP_ADDIU + k, flags, rt);
        end
        rt = $urandom;
        run_one("test_itype", i_word(6'h3f, $urandom, rt, $urandom), `OP_RSVD, 8'h00, rt);
    endtask

    task automatic test_control();
        logic [4:0] rt;
        logic [25:0] tgt;
        rt = $urandom;
        run_one("test_control", i_word(`OPC_BEQ, $urandom, rt, $urandom), `OP_BEQ, F_BR, rt);
        rt = $urandom;
        run_one("test_control", i_word(`OPC_BNE, $urandom, rt, $urandom), `OP_BNE, F_BR, rt);
        tgt = $urandom;
        run_one("test_control", {`OPC_J, tgt}, `OP_J, F_J, tgt[20:16]);
        tgt = $urandom;
        run_one("test_control", {`OPC_JAL, tgt}, `OP_JAL, F_J | F_WR, 5'd31);
        run_one("test_control", {`OPC_COP0, `COP0_CO, 15'd0, `C0F_TLBP}, `OP_TLBP, F_TLBP, 5'd0);
        run_one("test_control", {`OPC_COP0, `COP0_CO, 15'd0, `C0F_TLBR}, `OP_TLBR, F_TLBR, 5'd0);
        run_one("test_control", {`OPC_COP0, `COP0_CO, 15'd0, `C0F_TLBWI}, `OP_TLBWI,
                F_TLBWI, 5'd0);
    endtask

    task automatic test_stall();
        logic [4:0] rd;
        rd = $urandom;
        run_one("test_stall", r_word(`FN_ADDU, $urandom, $urandom, rd, $urandom),
                `OP_ADDU, F_WR, rd);
        rd = $urandom;
        apply_inst(r_word(`FN_SUBU, $urandom, $urandom, rd, $urandom), `OP_SUBU, F_WR, rd);
        stall_i <= 1'b1;
        next_edge();
        check_record("test_stall");
        @(posedge clk);
        flush_i <= 1'b1;     // Flush under stall still holds
        next_edge();
        check_record("test_stall");
        @(posedge clk);
        stall_i <= 1'b0;
        flush_i <= 1'b0;
        commit_expect();
        next_edge();
        check_record("test_stall");
    endtask

    task automatic test_clear();
        logic [4:0] rd;
        rd = $urandom;
        run_one("test_clear", r_word(`FN_OR, $urandom, $urandom, rd, $urandom), `OP_OR, F_WR, rd);
        @(posedge clk);
        valid_i <= 1'b0;     // Bubble
        clear_expect();
        next_edge();
        check_record("test_clear");
        rd = $urandom;
        run_one("test_clear", r_word(`FN_AND, $urandom, $urandom, rd, $urandom),
                `OP_AND, F_WR, rd);
        @(posedge clk);
        flush_i <= 1'b1;
        clear_expect();
        next_edge();
        check_record("test_clear");
        @(posedge clk);
        flush_i <= 1'b0;
        rd = $urandom;
        run_one("test_clear", r_word(`FN_SLT, $urandom, $urandom, rd, $urandom),
                `OP_SLT, F_WR, rd);
        @(posedge clk);
        stall_i <= 1'b1;
        exception_flush_i <= 1'b1;
        clear_expect();
        next_edge();
        check_record("test_clear");
        @(posedge clk);
        stall_i <= 1'b0;
        exception_flush_i <= 1'b0;
    endtask

    initial begin
        void'($urandom(17));
        clk = 1'b0;
        rst_i = 1'b1;
        flush_i = 1'b0;
        exception_flush_i = 1'b0;
        stall_i = 1'b0;
        valid_i = 1'b0;
        pc_i = '0;
        inst_i = '0;
        in_delay_slot_i = 1'b0;
        inst_adel_i = 1'b0;
        i_refill_tlbl_i = 1'b0;
        i_invalid_tlbl_i = 1'b0;
        refetch_i = 1'b0;
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        test_rtype();
        test_itype();
        test_control();
        test_stall();
        test_clear();
        next_edge();         // Pending checker properties complete
        chk_errors = i_decode_top.i_issue_id2.i_decode_chk.fail_count;
        $display("errors: %0d, assertion failures: %0d", errors, chk_errors);
        if (errors == 0 && chk_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+verilog
verilog/decode_pkg.sv
verilog/id1_if.sv
verilog/op_classifier.sv
verilog/operand_extract.sv
verilog/issue_id2.sv
verilog/decode_top.sv
verification/decode_chk.sv
verification/decode_tb.sv

/* Bender.yml */
package:
  name: decode_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/decode_pkg.sv
      - verilog/id1_if.sv
      - verilog/op_classifier.sv
      - verilog/operand_extract.sv
      - verilog/issue_id2.sv
      - verilog/decode_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/decode_chk.sv
      - verification/decode_tb.sv
